//--- common/sdram_map_pkg.sv
package sdram_map_pkg;

    // Slot order doubles as priority, lowest index wins
    typedef enum logic [2:0] {
        slot_vram_dma = 3'd0,
        slot_gfx      = 3'd1,
        slot_main_ram = 3'd2,
        slot_main_rom = 3'd3,
        slot_snd      = 3'd4
    } slot_id_t;

    localparam int NUM_SLOTS = 5;

    // SDRAM side
    localparam int SDRAM_AW = 22;   // Word address
    localparam int SDRAM_DW = 32;
    localparam int WR_DW    = 16;

    // Region bases, in words
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET   = 22'h20_0000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET  = 22'h30_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET   = 22'h00_0000;

    // Bank codes
    localparam logic [1:0] BANK_CPU = 2'd1;  // Main CPU ROM
    localparam logic [1:0] BANK_GFX = 2'd2;  // Graphics ROM
    localparam logic [1:0] BANK_SND = 2'd0;  // Sound ROM, work RAM and VRAM

    // Client address widths
    localparam int ROM_AW = 21;
    localparam int RAM_AW = 17;
    localparam int GFX_AW = 22;
    localparam int SND_AW = 16;
    localparam int DMA_AW = 17;

    // Client data widths
    localparam int ROM_DW = 16;
    localparam int RAM_DW = 16;
    localparam int GFX_DW = 32;
    localparam int SND_DW = 8;
    localparam int DMA_DW = 16;

endpackage

//--- common/sdram_bus_pkg.sv
package sdram_bus_pkg;

    import sdram_map_pkg::*;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } sdram_op_t;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_ack  = 2'd1,
        st_wait_data = 2'd2
    } arb_state_t;

    // One decoded client request, region offset already applied
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          bank;
        sdram_op_t           op;
        logic [1:0]          wrmask;  // Active low byte lanes
        logic [WR_DW-1:0]    din;
    } slot_cmd_t;

    // Command held toward the SDRAM controller
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          bank;
        sdram_op_t           op;
        logic [1:0]          wrmask;
        logic [WR_DW-1:0]    din;
    } sdram_cmd_t;

endpackage

//--- verilog/slot_decode.sv
module slot_decode
    import sdram_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                  main_rom_cs,
    input  logic [ROM_AW-1:0]     main_rom_addr,
    input  logic                  main_ram_cs,
    input  logic                  main_vram_cs,
    input  logic [RAM_AW-1:0]     ram_addr,
    input  logic                  main_rnw,
    input  logic [WR_DW-1:0]      main_dout,
    input  logic [1:0]            dsn,
    input  logic                  gfx_cs,
    input  logic [GFX_AW-1:0]     gfx_addr,
    input  logic                  snd_cs,
    input  logic [SND_AW-1:0]     snd_addr,
    input  logic                  vram_dma_cs,
    input  logic [DMA_AW-1:0]     vram_dma_addr,
    input  logic [NUM_SLOTS-1:0]  hit,
    input  logic [NUM_SLOTS-1:0]  busy,
    output logic [NUM_SLOTS-1:0]  pending,
    output slot_cmd_t [NUM_SLOTS-1:0] cmd
);

    logic [NUM_SLOTS-1:0] cs;

    always_comb begin
        cs[slot_vram_dma] = vram_dma_cs;
        cs[slot_gfx]      = gfx_cs;
        cs[slot_main_ram] = main_ram_cs | main_vram_cs;
        cs[slot_main_rom] = main_rom_cs;
        cs[slot_snd]      = snd_cs;
    end

    // Already served or in flight slots stay quiet
    assign pending = cs & ~hit & ~busy;

    always_comb begin
        cmd = '0;   // Read slots carry no write data

        // VRAM DMA reads the same region the CPU sees as VRAM
        cmd[slot_vram_dma].addr = VRAM_OFFSET + SDRAM_AW'(vram_dma_addr);
        cmd[slot_vram_dma].bank = BANK_SND;
        cmd[slot_vram_dma].op   = op_read;

        cmd[slot_gfx].addr = GFX_OFFSET + SDRAM_AW'(gfx_addr);
        cmd[slot_gfx].bank = BANK_GFX;
        cmd[slot_gfx].op   = op_read;

        // Work RAM and VRAM sit above the sound data in bank 0
        cmd[slot_main_ram].addr   = (main_ram_cs ? RAM_OFFSET : VRAM_OFFSET)
                                  + SDRAM_AW'(ram_addr);
        cmd[slot_main_ram].bank   = BANK_SND;
        cmd[slot_main_ram].op     = main_rnw ? op_read : op_write;
        cmd[slot_main_ram].wrmask = main_rnw ? 2'b00 : dsn;
        cmd[slot_main_ram].din    = main_dout;

        cmd[slot_main_rom].addr = SDRAM_AW'(main_rom_addr);  // CPU ROM starts bank 1
        cmd[slot_main_rom].bank = BANK_CPU;
        cmd[slot_main_rom].op   = op_read;

        cmd[slot_snd].addr = SOUND_OFFSET + SDRAM_AW'(snd_addr);
        cmd[slot_snd].bank = BANK_SND;
        cmd[slot_snd].op   = op_read;
    end

endmodule

//--- arbiter/slot_arbiter.sv
module slot_arbiter
    import sdram_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [NUM_SLOTS-1:0]      pending,
    input  slot_cmd_t [NUM_SLOTS-1:0] cmd,
    input  logic                      sdram_ack,
    input  logic                      data_rdy,
    input  logic [SDRAM_DW-1:0]       data_read,
    output logic [NUM_SLOTS-1:0]      busy,
    output logic                      done,
    output slot_id_t                  done_slot,
    output logic [SDRAM_DW-1:0]       done_data,
    output logic                      sdram_req,
    output logic [SDRAM_AW-1:0]       sdram_addr,
    output logic [1:0]                sdram_bank,
    output logic                      sdram_rnw,
    output logic [1:0]                sdram_wrmask,
    output logic [WR_DW-1:0]          data_write
);

    arb_state_t state;
    slot_id_t   sel;
    slot_id_t   pick;
    logic       any_pending;
    sdram_cmd_t cmd_q;

    // Scan from the bottom so the lowest pending index is kept
    always_comb begin
        pick        = slot_snd;
        any_pending = 1'b0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick        = slot_id_t'(i);
                any_pending = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            sel   <= slot_vram_dma;
        end else begin
            case (state)
                st_idle: begin
                    if (any_pending) begin
                        state <= st_wait_ack;
                        sel   <= pick;
                    end
                end
                st_wait_ack: begin
                    if (sdram_ack) state <= st_wait_data;
                end
                st_wait_data: begin
                    if (data_rdy) state <= st_idle;  // Ends writes too
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Command frozen for the whole access
    always_ff @(posedge clk) begin
        if (state == st_idle && any_pending) begin
            cmd_q <= sdram_cmd_t'(cmd[pick]);
        end
    end

    always_comb begin
        busy = '0;
        if (state != st_idle) busy[sel] = 1'b1;
    end

    assign sdram_req    = state == st_wait_ack;
    assign sdram_addr   = cmd_q.addr;
    assign sdram_bank   = cmd_q.bank;
    assign sdram_rnw    = cmd_q.op == op_read;
    assign sdram_wrmask = cmd_q.wrmask;
    assign data_write   = cmd_q.din;

    assign done      = state == st_wait_data && data_rdy;
    assign done_slot = sel;
    // A write hands back its own word so the client sees it on ok
    assign done_data = cmd_q.op == op_write ? SDRAM_DW'(cmd_q.din) : data_read;

endmodule

//--- verilog/slot_return.sv
module slot_return
    import sdram_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  main_rom_cs,
    input  logic [ROM_AW-1:0]     main_rom_addr,
    input  logic                  main_ram_cs,
    input  logic                  main_vram_cs,
    input  logic [RAM_AW-1:0]     ram_addr,
    input  logic                  gfx_cs,
    input  logic [GFX_AW-1:0]     gfx_addr,
    input  logic                  snd_cs,
    input  logic [SND_AW-1:0]     snd_addr,
    input  logic                  vram_dma_cs,
    input  logic [DMA_AW-1:0]     vram_dma_addr,
    input  logic                  done,
    input  slot_id_t              done_slot,
    input  logic [SDRAM_DW-1:0]   done_data,
    output logic [NUM_SLOTS-1:0]  hit,
    output logic [ROM_DW-1:0]     main_rom_data,
    output logic                  main_rom_ok,
    output logic [RAM_DW-1:0]     main_ram_data,
    output logic                  main_ram_ok,
    output logic [GFX_DW-1:0]     gfx_data,
    output logic                  gfx_ok,
    output logic [SND_DW-1:0]     snd_data,
    output logic                  snd_ok,
    output logic [DMA_DW-1:0]     vram_dma_data,
    output logic                  vram_dma_ok
);

    logic [NUM_SLOTS-1:0] cs;
    logic [SDRAM_AW-1:0]  key    [NUM_SLOTS];
    logic [SDRAM_AW-1:0]  key_q  [NUM_SLOTS];
    logic [SDRAM_DW-1:0]  data_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] valid_q;

    always_comb begin
        cs[slot_vram_dma]  = vram_dma_cs;
        cs[slot_gfx]       = gfx_cs;
        cs[slot_main_ram]  = main_ram_cs | main_vram_cs;
        cs[slot_main_rom]  = main_rom_cs;
        cs[slot_snd]       = snd_cs;
        key[slot_vram_dma] = SDRAM_AW'(vram_dma_addr);
        key[slot_gfx]      = gfx_addr;
        key[slot_main_ram] = SDRAM_AW'({main_ram_cs, ram_addr});  // RAM and VRAM differ
        key[slot_main_rom] = SDRAM_AW'(main_rom_addr);
        key[slot_snd]      = SDRAM_AW'(snd_addr);
    end

    // Entry dropped once the client lets go of cs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (done && done_slot == slot_id_t'(i)) valid_q[i] <= 1'b1;
                else if (!cs[i]) valid_q[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            key_q[done_slot]  <= key[done_slot];
            data_q[done_slot] <= done_data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            hit[i] = valid_q[i] & cs[i] & (key_q[i] == key[i]);
        end
    end

    assign main_rom_ok   = hit[slot_main_rom];
    assign main_ram_ok   = hit[slot_main_ram];
    assign gfx_ok        = hit[slot_gfx];
    assign snd_ok        = hit[slot_snd];
    assign vram_dma_ok   = hit[slot_vram_dma];

    assign main_rom_data = data_q[slot_main_rom][ROM_DW-1:0];
    assign main_ram_data = data_q[slot_main_ram][RAM_DW-1:0];
    assign gfx_data      = data_q[slot_gfx][GFX_DW-1:0];
    assign snd_data      = data_q[slot_snd][SND_DW-1:0];
    assign vram_dma_data = data_q[slot_vram_dma][DMA_DW-1:0];

endmodule

//--- verilog/sdram_slot_mux.sv
module sdram_slot_mux
    import sdram_map_pkg::*, sdram_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // Main CPU
    input  logic                 main_rom_cs,
    input  logic [ROM_AW-1:0]    main_rom_addr,
    output logic [ROM_DW-1:0]    main_rom_data,
    output logic                 main_rom_ok,
    input  logic                 main_ram_cs,
    input  logic                 main_vram_cs,
    input  logic [RAM_AW-1:0]    ram_addr,
    input  logic                 main_rnw,
    input  logic [WR_DW-1:0]     main_dout,
    input  logic [1:0]           dsn,
    output logic [RAM_DW-1:0]    main_ram_data,
    output logic                 main_ram_ok,
    // Graphics, sound and DMA clients
    input  logic                 gfx_cs,
    input  logic [GFX_AW-1:0]    gfx_addr,
    output logic [GFX_DW-1:0]    gfx_data,
    output logic                 gfx_ok,
    input  logic                 snd_cs,
    input  logic [SND_AW-1:0]    snd_addr,
    output logic [SND_DW-1:0]    snd_data,
    output logic                 snd_ok,
    input  logic                 vram_dma_cs,
    input  logic [DMA_AW-1:0]    vram_dma_addr,
    output logic [DMA_DW-1:0]    vram_dma_data,
    output logic                 vram_dma_ok,
    // SDRAM controller
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    output logic [1:0]           sdram_bank,
    output logic                 sdram_rnw,
    output logic [1:0]           sdram_wrmask,
    output logic [WR_DW-1:0]     data_write,
    input  logic                 data_rdy,
    input  logic [SDRAM_DW-1:0]  data_read
);

    logic [NUM_SLOTS-1:0]      pending;
    logic [NUM_SLOTS-1:0]      busy;
    logic [NUM_SLOTS-1:0]      hit;
    slot_cmd_t [NUM_SLOTS-1:0] cmd;
    logic                      done;
    slot_id_t                  done_slot;
    logic [SDRAM_DW-1:0]       done_data;

    slot_decode i_slot_decode (
        .main_rom_cs   (main_rom_cs),
        .main_rom_addr (main_rom_addr),
        .main_ram_cs   (main_ram_cs),
        .main_vram_cs  (main_vram_cs),
        .ram_addr      (ram_addr),
        .main_rnw      (main_rnw),
        .main_dout     (main_dout),
        .dsn           (dsn),
        .gfx_cs        (gfx_cs),
        .gfx_addr      (gfx_addr),
        .snd_cs        (snd_cs),
        .snd_addr      (snd_addr),
        .vram_dma_cs   (vram_dma_cs),
        .vram_dma_addr (vram_dma_addr),
        .hit           (hit),
        .busy          (busy),
        .pending       (pending),
        .cmd           (cmd)
    );

    slot_arbiter i_slot_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .pending      (pending),
        .cmd          (cmd),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read),
        .busy         (busy),
        .done         (done),
        .done_slot    (done_slot),
        .done_data    (done_data),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write)
    );

    slot_return i_slot_return (
        .clk           (clk),
        .rst_n         (rst_n),
        .main_rom_cs   (main_rom_cs),
        .main_rom_addr (main_rom_addr),
        .main_ram_cs   (main_ram_cs),
        .main_vram_cs  (main_vram_cs),
        .ram_addr      (ram_addr),
        .gfx_cs        (gfx_cs),
        .gfx_addr      (gfx_addr),
        .snd_cs        (snd_cs),
        .snd_addr      (snd_addr),
        .vram_dma_cs   (vram_dma_cs),
        .vram_dma_addr (vram_dma_addr),
        .done          (done),
        .done_slot     (done_slot),
        .done_data     (done_data),
        .hit           (hit),
        .main_rom_data (main_rom_data),
        .main_rom_ok   (main_rom_ok),
        .main_ram_data (main_ram_data),
        .main_ram_ok   (main_ram_ok),
        .gfx_data      (gfx_data),
        .gfx_ok        (gfx_ok),
        .snd_data      (snd_data),
        .snd_ok        (snd_ok),
        .vram_dma_data (vram_dma_data),
        .vram_dma_ok   (vram_dma_ok)
    );

endmodule

//--- test/sdram_slot_mux_props.sv
module sdram_slot_mux_props
    import sdram_map_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                sdram_req,
    input logic                sdram_ack,
    input logic [SDRAM_AW-1:0] sdram_addr,
    input logic [1:0]          sdram_bank,
    input logic                sdram_rnw,
    input logic [1:0]          sdram_wrmask,
    input logic [WR_DW-1:0]    data_write
);

    timeunit 1ns;
    timeprecision 100ps;

    // Request stays up until the controller takes it
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=>
            $stable({sdram_addr, sdram_bank, sdram_rnw, sdram_wrmask, data_write}))
        else $error("SDRAM command changed while waiting for sdram_ack");

    req_low_in_reset: assert property (@(posedge clk) !rst_n |=> !sdram_req)
        else $error("sdram_req high after a reset cycle");

endmodule

bind slot_arbiter sdram_slot_mux_props i_sdram_slot_mux_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .sdram_req    (sdram_req),
    .sdram_ack    (sdram_ack),
    .sdram_addr   (sdram_addr),
    .sdram_bank   (sdram_bank),
    .sdram_rnw    (sdram_rnw),
    .sdram_wrmask (sdram_wrmask),
    .data_write   (data_write)
);

//--- test/tb_sdram_slot_mux.sv
module tb_sdram_slot_mux
    import sdram_map_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // About 36 accesses, the slow ones near 30 cycles each
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          bank;
        logic                rnw;
        logic [1:0]          wrmask;
        logic [WR_DW-1:0]    din;
    } ack_rec_t;

    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          bank;
        logic                rnw;
        logic [1:0]          wrmask;
        logic [SDRAM_DW-1:0] data;
    } expect_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                main_rom_cs;
    logic [ROM_AW-1:0]   main_rom_addr;
    logic [ROM_DW-1:0]   main_rom_data;
    logic                main_rom_ok;
    logic                main_ram_cs;
    logic                main_vram_cs;
    logic [RAM_AW-1:0]   ram_addr;
    logic                main_rnw;
    logic [WR_DW-1:0]    main_dout;
    logic [1:0]          dsn;
    logic [RAM_DW-1:0]   main_ram_data;
    logic                main_ram_ok;
    logic                gfx_cs;
    logic [GFX_AW-1:0]   gfx_addr;
    logic [GFX_DW-1:0]   gfx_data;
    logic                gfx_ok;
    logic                snd_cs;
    logic [SND_AW-1:0]   snd_addr;
    logic [SND_DW-1:0]   snd_data;
    logic                snd_ok;
    logic                vram_dma_cs;
    logic [DMA_AW-1:0]   vram_dma_addr;
    logic [DMA_DW-1:0]   vram_dma_data;
    logic                vram_dma_ok;
    logic                sdram_req;
    logic                sdram_ack;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [1:0]          sdram_bank;
    logic                sdram_rnw;
    logic [1:0]          sdram_wrmask;
    logic [WR_DW-1:0]    data_write;
    logic                data_rdy;
    logic [SDRAM_DW-1:0] data_read;

    ack_rec_t             ack_log [$];           // Every command the controller took
    logic [SDRAM_DW-1:0]  model_mem [logic [23:0]];
    logic [SDRAM_DW-1:0]  written [logic [23:0]]; // Words the tests wrote, by bank and address
    expect_t              exp_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] ok_vec;
    logic [NUM_SLOTS-1:0] ok_prev = '0;
    logic [SDRAM_DW-1:0]  data_vec [NUM_SLOTS];
    bit                   long_delays = 1'b0;
    int                   ack_count = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   cycles = 0;

    sdram_slot_mux i_sdram_slot_mux (.*);

    always #10 clk = ~clk;

    always_comb begin
        ok_vec[slot_vram_dma]   = vram_dma_ok;
        ok_vec[slot_gfx]        = gfx_ok;
        ok_vec[slot_main_ram]   = main_ram_ok;
        ok_vec[slot_main_rom]   = main_rom_ok;
        ok_vec[slot_snd]        = snd_ok;
        data_vec[slot_vram_dma] = 32'(vram_dma_data);
        data_vec[slot_gfx]      = gfx_data;
        data_vec[slot_main_ram] = 32'(main_ram_data);
        data_vec[slot_main_rom] = 32'(main_rom_data);
        data_vec[slot_snd]      = 32'(snd_data);
    end

    // Contents of untouched SDRAM
    function automatic logic [31:0] mem_word(input logic [1:0] bank, input logic [21:0] addr);
        return (32'(addr) * 32'h9e37_79b1) ^ {bank, 30'h15a5_c3e1};
    endfunction

    function automatic expect_t ref_access(input slot_id_t s, input logic [21:0] a,
                                           input logic vram, input logic wr,
                                           input logic [15:0] wdata, input logic [1:0] mask);
        expect_t             e;
        logic [SDRAM_DW-1:0] word;
        e = '0;
        case (s)
            slot_vram_dma: e.addr = 22'h30_0000 + a;
            slot_main_ram: e.addr = (vram ? 22'h30_0000 : 22'h20_0000) + a;
            default:       e.addr = a;  // ROM, gfx and sound sit at base 0
        endcase
        e.bank   = s == slot_gfx ? 2'd2 : s == slot_main_rom ? 2'd1 : 2'd0;
        e.rnw    = !wr;
        e.wrmask = wr ? mask : 2'b00;
        if (wr) word = 32'(wdata);
        else if (written.exists({e.bank, e.addr})) word = written[{e.bank, e.addr}];
        else word = mem_word(e.bank, e.addr);
        case (s)
            slot_gfx: e.data = word;
            slot_snd: e.data = {24'h0, word[7:0]};
            default:  e.data = {16'h0, word[15:0]};
        endcase
        return e;
    endfunction

    function automatic logic [21:0] addr_mask(input slot_id_t s);
        case (s)
            slot_gfx:      return 22'h3f_ffff;
            slot_main_rom: return 22'h1f_ffff;
            slot_snd:      return 22'h00_ffff;
            default:       return 22'h01_ffff;
        endcase
    endfunction

    function automatic string slot_name(input slot_id_t s);
        case (s)
            slot_vram_dma: return "vram_dma";
            slot_gfx:      return "gfx";
            slot_main_ram: return "main_ram";
            slot_main_rom: return "main_rom";
            default:       return "snd";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        if (!cond) begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic compare_slot(input slot_id_t s);
        ack_rec_t last;
        last = '0;
        if (ack_log.size() > 0) last = ack_log[$];
        check_value({slot_name(s), "_data"}, exp_q[s].data, data_vec[s]);
        check_value("sdram_addr", 32'(exp_q[s].addr), 32'(last.addr));
        check_value("sdram_bank", 32'(exp_q[s].bank), 32'(last.bank));
        check_value("sdram_rnw", 32'(exp_q[s].rnw), 32'(last.rnw));
        if (!exp_q[s].rnw) begin
            check_value("sdram_wrmask", 32'(exp_q[s].wrmask), 32'(last.wrmask));
            check_value("data_write", exp_q[s].data, 32'(last.din));
        end
    endtask

    // Arms the expectation, then raises cs with the new address
    task automatic start_access(input slot_id_t s, input logic [21:0] a, input logic vram,
                                input logic wr, input logic [15:0] wdata,
                                input logic [1:0] mask);
        exp_q[s] = ref_access(s, a, vram, wr, wdata, mask);
        if (wr) written[{exp_q[s].bank, exp_q[s].addr}] = 32'(wdata);
        case (s)
            slot_vram_dma: begin
                vram_dma_cs   <= 1'b1;
                vram_dma_addr <= a[DMA_AW-1:0];
            end
            slot_gfx: begin
                gfx_cs   <= 1'b1;
                gfx_addr <= a;
            end
            slot_main_ram: begin
                main_ram_cs  <= !vram;
                main_vram_cs <= vram;
                ram_addr     <= a[RAM_AW-1:0];
                main_rnw     <= !wr;
                main_dout    <= wdata;
                dsn          <= mask;
            end
            slot_main_rom: begin
                main_rom_cs   <= 1'b1;
                main_rom_addr <= a[ROM_AW-1:0];
            end
            default: begin
                snd_cs   <= 1'b1;
                snd_addr <= a[SND_AW-1:0];
            end
        endcase
    endtask

    task automatic release_client(input slot_id_t s);
        case (s)
            slot_vram_dma: vram_dma_cs <= 1'b0;
            slot_gfx:      gfx_cs <= 1'b0;
            slot_main_ram: begin
                main_ram_cs  <= 1'b0;
                main_vram_cs <= 1'b0;
                main_rnw     <= 1'b1;
            end
            slot_main_rom: main_rom_cs <= 1'b0;
            default:       snd_cs <= 1'b0;
        endcase
    endtask

    task automatic wait_ok(input slot_id_t s);
        while (!ok_vec[s]) @(posedge clk);
    endtask

    task automatic access(input slot_id_t s, input logic [21:0] a, input logic vram,
                          input logic wr, input logic [15:0] wdata, input logic [1:0] mask);
        @(posedge clk);
        start_access(s, a, vram, wr, wdata, mask);
        wait_ok(s);
        release_client(s);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) $display("Test %s: passed", name);
        else $display("Test %s: failed with %0d errors", name, errors - err_before);
    endtask

    // SDRAM controller model
    initial begin : sdram_model
        ack_rec_t    rec;
        int          delay;
        logic [23:0] key;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (rst_n && sdram_req) begin
                delay = long_delays ? $urandom_range(12, 1) : $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                rec.addr   = sdram_addr;
                rec.bank   = sdram_bank;
                rec.rnw    = sdram_rnw;
                rec.wrmask = sdram_wrmask;
                rec.din    = data_write;
                ack_log.push_back(rec);
                ack_count++;
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                delay = long_delays ? $urandom_range(10, 1) : $urandom_range(3, 1);
                repeat (delay - 1) @(posedge clk);
                key = {rec.bank, rec.addr};
                if (!rec.rnw) model_mem[key] = 32'(rec.din);
                data_read <= model_mem.exists(key) ? model_mem[key] : mem_word(rec.bank, rec.addr);
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

    // Compares each slot when its ok rises
    always @(posedge clk) begin
        ok_prev <= ok_vec;
        if (rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ok_vec[i] && !ok_prev[i]) compare_slot(slot_id_t'(i));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin : stimulus
        int          e0;
        int          n;
        int          base;
        slot_id_t    s;
        logic [21:0] a;
        logic [21:0] first_addr;
        logic        vram;
        logic        wr;
        void'($urandom(32'h95a9));
        rst_n         = 1'b0;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        main_ram_cs   = 1'b0;
        main_vram_cs  = 1'b0;
        ram_addr      = '0;
        main_rnw      = 1'b1;
        main_dout     = '0;
        dsn           = 2'b00;
        gfx_cs        = 1'b0;
        gfx_addr      = '0;
        snd_cs        = 1'b0;
        snd_addr      = '0;
        vram_dma_cs   = 1'b0;
        vram_dma_addr = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        e0 = errors;
        check_true(!sdram_req && ok_vec == '0, "sdram_req or an ok output high after reset");
        access(slot_vram_dma, 22'h01_2345, 1'b0, 1'b0, 16'h0, 2'b00);
        access(slot_gfx, 22'h3a_5c71, 1'b0, 1'b0, 16'h0, 2'b00);
        access(slot_main_ram, 22'h00_0abc, 1'b0, 1'b0, 16'h0, 2'b00);
        access(slot_main_rom, 22'h1f_0123, 1'b0, 1'b0, 16'h0, 2'b00);
        access(slot_snd, 22'h00_beef, 1'b0, 1'b0, 16'h0, 2'b00);
        report_test("single read per slot", e0);

        e0 = errors;
        access(slot_main_ram, 22'h01_5555, 1'b0, 1'b0, 16'h0, 2'b00);
        first_addr = ack_log[$].addr;
        access(slot_main_ram, 22'h01_5555, 1'b1, 1'b0, 16'h0, 2'b00);
        check_value("sdram_addr", 32'h0010_0000, 32'(ack_log[$].addr - first_addr));
        report_test("ram and vram views", e0);

        e0 = errors;
        access(slot_main_ram, 22'h00_0777, 1'b0, 1'b1, 16'hc0de, 2'b10);
        access(slot_main_ram, 22'h00_0777, 1'b0, 1'b0, 16'h0, 2'b00);
        report_test("write then read back", e0);

        // All five raise cs on the same edge
        e0 = errors;
        base = ack_log.size();
        @(posedge clk);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            start_access(slot_id_t'(i), 22'h00_2100 + 22'(i), 1'b0, 1'b0, 16'h0, 2'b00);
        end
        while (ok_vec != '1) @(posedge clk);
        check_true(ack_log.size() == base + NUM_SLOTS, "Wrong number of requests for five slots");
        for (int i = 0; i < NUM_SLOTS; i++) begin
            check_value("sdram_addr", 32'(exp_q[i].addr), 32'(ack_log[base + i].addr));
        end
        for (int i = 0; i < NUM_SLOTS; i++) release_client(slot_id_t'(i));
        report_test("priority order", e0);

        e0 = errors;
        @(posedge clk);
        start_access(slot_gfx, 22'h12_3456, 1'b0, 1'b0, 16'h0, 2'b00);
        wait_ok(slot_gfx);
        n = ack_count;
        repeat (10) begin
            @(posedge clk);
            check_true(ok_vec[slot_gfx] && !sdram_req,
                       "gfx_ok dropped or a request appeared while cs and address were held");
        end
        start_access(slot_gfx, 22'h12_3457, 1'b0, 1'b0, 16'h0, 2'b00);
        @(posedge clk);
        check_true(!ok_vec[slot_gfx], "gfx_ok stayed high after the address changed");
        wait_ok(slot_gfx);
        repeat (8) @(posedge clk);
        check_true(ack_count == n + 1, "Address change did not cause exactly one new request");
        release_client(slot_gfx);
        report_test("hold and address change", e0);

        // Slow controller with random clients
        e0 = errors;
        long_delays = 1'b1;
        for (int k = 0; k < 20; k++) begin
            s    = slot_id_t'($urandom_range(4, 0));
            a    = 22'($urandom) & addr_mask(s);
            vram = 1'($urandom_range(1, 0));
            wr   = s == slot_main_ram && $urandom_range(3, 0) == 0;
            access(s, a, vram, wr, 16'($urandom), 2'($urandom_range(3, 0)));
        end
        long_delays = 1'b0;
        report_test("random slow controller", e0);

        repeat (4) @(posedge clk);
        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src.f
common/sdram_map_pkg.sv
common/sdram_bus_pkg.sv
verilog/slot_decode.sv
arbiter/slot_arbiter.sv
verilog/slot_return.sv
verilog/sdram_slot_mux.sv
test/sdram_slot_mux_props.sv
test/tb_sdram_slot_mux.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_slot_mux -f src.f -o tb_sdram_slot_mux > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sdram_slot_mux > sim.log 2>&1
cat sim.log

grep -qx "No errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
